//--- Makefile
TB_TOP := tb_load_store_pipe

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f load_store_pipe.f --top-module load_store_pipe

sim:
	verilator --binary --timing --assert -f load_store_pipe.f \
		--top-module $(TB_TOP) --Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	@grep -q "Done: no errors" sim.log || (echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

//--- load_store_pipe.f
+incdir+test
verilog/lsu_pkg.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/data_ram.sv
verilog/load_store_pipe.sv
test/tb_load_store_pipe.sv

//--- test/lsu_vectors.svh
typedef struct {
    string                          name;
    lsu_pkg::lsu_op_e               op;
    logic [lsu_pkg::xlen-1:0]       pc;
    logic [lsu_pkg::xlen-1:0]       base;
    logic [lsu_pkg::xlen-1:0]       offset;
    logic [lsu_pkg::xlen-1:0]       wdata;
    logic [lsu_pkg::reg_addr_w-1:0] rd;
    logic                           exp_we;
    logic [lsu_pkg::xlen-1:0]       exp_wdata;
    logic                           exp_ale;
} lsu_vector_t;

lsu_vector_t rows[$];

task automatic add_row(input string name, input lsu_pkg::lsu_op_e op,
                       input logic [31:0] pc, input logic [31:0] base,
                       input logic [31:0] offset, input logic [31:0] wdata,
                       input logic [4:0] rd, input logic exp_we,
                       input logic [31:0] exp_wdata, input logic exp_ale);
    lsu_vector_t v;
    v.name      = name;
    v.op        = op;
    v.pc        = pc;
    v.base      = base;
    v.offset    = offset;
    v.wdata     = wdata;
    v.rd        = rd;
    v.exp_we    = exp_we;
    v.exp_wdata = exp_wdata;
    v.exp_ale   = exp_ale;
    rows.push_back(v);
endtask

// columns: name, op, pc, base, offset, wdata, rd, then expected we, wdata, ale
// stores and faults retire with we low and the byte address as data
task automatic load_rows();
    add_row("alu_pass", lsu_pkg::op_alu, 32'h1000, 32'h1234_5678, 32'h10, 32'h0,
            5'd1, 1'b1, 32'h1234_5678, 1'b0);
    add_row("st_w_40", lsu_pkg::op_st_w, 32'h1004, 32'h40, 32'h0, 32'hdead_beef,
            5'd0, 1'b0, 32'h40, 1'b0);
    add_row("ld_w_40", lsu_pkg::op_ld_w, 32'h1008, 32'h30, 32'h10, 32'h0,
            5'd2, 1'b1, 32'hdead_beef, 1'b0);
    // word at 0x80 becomes c3f1_7a85, built lane by lane
    add_row("st_b_80", lsu_pkg::op_st_b, 32'h100c, 32'h90, 32'hffff_fff0, 32'h85,
            5'd0, 1'b0, 32'h80, 1'b0);
    add_row("st_b_81", lsu_pkg::op_st_b, 32'h1010, 32'h80, 32'h1, 32'h7a,
            5'd0, 1'b0, 32'h81, 1'b0);
    add_row("st_h_82", lsu_pkg::op_st_h, 32'h1014, 32'h80, 32'h2, 32'h5555_c3f1,
            5'd0, 1'b0, 32'h82, 1'b0);
    add_row("ld_b_80", lsu_pkg::op_ld_b, 32'h1018, 32'h80, 32'h0, 32'h0,
            5'd3, 1'b1, 32'hffff_ff85, 1'b0);
    add_row("ld_bu_80", lsu_pkg::op_ld_bu, 32'h101c, 32'h80, 32'h0, 32'h0,
            5'd4, 1'b1, 32'h0000_0085, 1'b0);
    add_row("ld_b_81", lsu_pkg::op_ld_b, 32'h1020, 32'h80, 32'h1, 32'h0,
            5'd5, 1'b1, 32'h0000_007a, 1'b0);
    add_row("ld_bu_83", lsu_pkg::op_ld_bu, 32'h1024, 32'h83, 32'h0, 32'h0,
            5'd6, 1'b1, 32'h0000_00c3, 1'b0);
    add_row("ld_h_82", lsu_pkg::op_ld_h, 32'h1028, 32'h80, 32'h2, 32'h0,
            5'd7, 1'b1, 32'hffff_c3f1, 1'b0);
    add_row("ld_hu_82", lsu_pkg::op_ld_hu, 32'h102c, 32'h80, 32'h2, 32'h0,
            5'd8, 1'b1, 32'h0000_c3f1, 1'b0);
    add_row("ld_h_80", lsu_pkg::op_ld_h, 32'h1030, 32'h80, 32'h0, 32'h0,
            5'd9, 1'b1, 32'h0000_7a85, 1'b0);
    add_row("ld_w_80", lsu_pkg::op_ld_w, 32'h1034, 32'h7c, 32'h4, 32'h0,
            5'd10, 1'b1, 32'hc3f1_7a85, 1'b0);
    add_row("ld_h_ale_81", lsu_pkg::op_ld_h, 32'h1038, 32'h80, 32'h1, 32'h0,
            5'd11, 1'b0, 32'h81, 1'b1);
    add_row("ld_w_ale_42", lsu_pkg::op_ld_w, 32'h103c, 32'h40, 32'h2, 32'h0,
            5'd12, 1'b0, 32'h42, 1'b1);
    add_row("st_w_ale_41", lsu_pkg::op_st_w, 32'h1040, 32'h40, 32'h1, 32'h1122_3344,
            5'd0, 1'b0, 32'h41, 1'b1);
    // memory untouched by the faulting store
    add_row("ld_w_40_after", lsu_pkg::op_ld_w, 32'h1044, 32'h40, 32'h0, 32'h0,
            5'd13, 1'b1, 32'hdead_beef, 1'b0);
    add_row("ld_hu_42", lsu_pkg::op_ld_hu, 32'h1048, 32'h40, 32'h2, 32'h0,
            5'd14, 1'b1, 32'h0000_dead, 1'b0);
    add_row("alu_neg", lsu_pkg::op_alu, 32'h104c, 32'hffff_0000, 32'h3, 32'h0,
            5'd15, 1'b1, 32'hffff_0000, 1'b0);
endtask

//--- test/tb_load_store_pipe.sv
`timescale 1ns/1ps

module tb_load_store_pipe;

    localparam int ram_words    = 256;
    localparam int resp_latency = 2;

    logic                           clk;
    logic                           resetn;
    logic                           in_valid;
    logic                           in_ready;
    lsu_pkg::lsu_op_e               in_op;
    logic [lsu_pkg::xlen-1:0]       in_pc;
    logic [lsu_pkg::xlen-1:0]       in_base;
    logic [lsu_pkg::xlen-1:0]       in_offset;
    logic [lsu_pkg::xlen-1:0]       in_wdata;
    logic [lsu_pkg::reg_addr_w-1:0] in_rd;
    logic                           retire_ready;
    logic                           retire_valid;
    logic [lsu_pkg::xlen-1:0]       retire_pc;
    logic [lsu_pkg::reg_addr_w-1:0] retire_rd;
    logic                           retire_we;
    logic [lsu_pkg::xlen-1:0]       retire_wdata;
    logic                           retire_excp_ale;

    int          pass_count;
    int          fail_count;
    int          retired;
    int          cycles;
    int          limit;
    bit          timed_out;
    bit          extra_retire;

    `include "lsu_vectors.svh"

    load_store_pipe #(
        .ram_words    (ram_words),
        .resp_latency (resp_latency)
    ) load_store_pipe_inst (.*);

    task automatic check_retire(input int idx);
        bit ok;
        ok = 1'b1;
        if (retire_pc !== rows[idx].pc) begin
            $display("** Error %s: pc expected %08h actual %08h",
                     rows[idx].name, rows[idx].pc, retire_pc);
            ok = 1'b0;
        end
        if (retire_rd !== rows[idx].rd) begin
            $display("** Error %s: rd expected %0d actual %0d",
                     rows[idx].name, rows[idx].rd, retire_rd);
            ok = 1'b0;
        end
        if (retire_we !== rows[idx].exp_we) begin
            $display("** Error %s: we expected %0b actual %0b",
                     rows[idx].name, rows[idx].exp_we, retire_we);
            ok = 1'b0;
        end
        if (retire_wdata !== rows[idx].exp_wdata) begin
            $display("** Error %s: wdata expected %08h actual %08h",
                     rows[idx].name, rows[idx].exp_wdata, retire_wdata);
            ok = 1'b0;
        end
        if (retire_excp_ale !== rows[idx].exp_ale) begin
            $display("** Error %s: ale expected %0b actual %0b",
                     rows[idx].name, rows[idx].exp_ale, retire_excp_ale);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("test %s passed", rows[idx].name);
        end else begin
            fail_count++;
            $display("test %s failed", rows[idx].name);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        load_rows();
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_op        = lsu_pkg::op_alu;
        in_pc        = '0;
        in_base      = '0;
        in_offset    = '0;
        in_wdata     = '0;
        in_rd        = '0;
        retire_ready = 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
    end

    // driver, one row per accepted handshake
    initial begin
        wait (resetn === 1'b1);
        @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            in_valid  <= 1'b1;
            in_op     <= rows[i].op;
            in_pc     <= rows[i].pc;
            in_base   <= rows[i].base;
            in_offset <= rows[i].offset;
            in_wdata  <= rows[i].wdata;
            in_rd     <= rows[i].rd;
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        in_valid <= 1'b0;
    end

    // random stall bursts on the retire port that can reach back into MEM
    initial begin
        void'($urandom(32'haeff_2f5a));
        wait (resetn === 1'b1);
        forever begin
            repeat ($urandom % 6) begin
                @(posedge clk);
                retire_ready <= 1'b0;
            end
            repeat (1 + $urandom % 3) begin
                @(posedge clk);
                retire_ready <= 1'b1;
            end
        end
    end

    initial begin
        pass_count   = 0;
        fail_count   = 0;
        retired      = 0;
        cycles       = 0;
        timed_out    = 1'b0;
        extra_retire = 1'b0;
        wait (resetn === 1'b1);
        // memory clear sweep runs first
        limit = ram_words + rows.size() * (resp_latency + 4) * 4;
        while (retired < rows.size() && cycles < limit) begin
            @(posedge clk);
            cycles++;
            if (retire_valid && retire_ready) begin
                check_retire(retired);
                retired++;
            end
        end
        if (retired < rows.size()) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d instructions retired after %0d cycles",
                     retired, rows.size(), cycles);
        end else begin
            repeat (resp_latency + 4) begin
                @(posedge clk);
                if (retire_valid) begin
                    extra_retire = 1'b1;
                end
            end
            if (extra_retire) begin
                $display("an instruction retired after the last row had already retired");
            end
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out && !extra_retire) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_words    = 256,
    parameter int resp_latency = 2
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     data_req,
    input  logic                     data_wr,
    input  logic [3:0]               data_wstrb,
    input  logic [lsu_pkg::xlen-1:0] data_addr,
    input  logic [lsu_pkg::xlen-1:0] data_wdata,
    output logic                     data_addr_ok,
    output logic                     data_ok,
    output logic [lsu_pkg::xlen-1:0] data_rdata
);

    localparam int idx_w = $clog2(ram_words);
    localparam int cnt_w = $clog2(resp_latency + 1);

    logic [lsu_pkg::xlen-1:0] mem [ram_words];
    logic [idx_w-1:0]         sweep_idx;
    logic                     sweeping;
    logic                     busy;
    logic [cnt_w-1:0]         cnt;
    logic [idx_w-1:0]         word_idx;
    logic                     accept;

    // word index wraps with the depth
    assign word_idx     = data_addr[2 +: idx_w];
    assign data_addr_ok = ~busy & ~sweeping;
    assign accept       = data_req & data_addr_ok;
    assign data_ok      = busy & (cnt == '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
            busy      <= 1'b0;
            cnt       <= '0;
        end else begin
            if (sweeping) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == idx_w'(ram_words - 1)) begin
                    sweeping <= 1'b0;
                end
            end
            if (accept) begin
                busy <= 1'b1;
                cnt  <= cnt_w'(resp_latency - 1);
            end else if (busy) begin
                if (cnt == '0) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    // clear sweep first, then strobed writes
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_idx] <= '0;
        end else if (accept && data_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (data_wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end
        end
    end

    // read data captured at acceptance
    always_ff @(posedge clk) begin
        if (accept && !data_wr) begin
            data_rdata <= mem[word_idx];
        end
    end

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                          clk,
    input  logic                          resetn,
    // from the issue side
    input  logic                          in_valid,
    output logic                          in_ready,
    input  lsu_pkg::lsu_op_e              in_op,
    input  logic [lsu_pkg::xlen-1:0]      in_pc,
    input  logic [lsu_pkg::xlen-1:0]      in_base,
    input  logic [lsu_pkg::xlen-1:0]      in_offset,
    input  logic [lsu_pkg::xlen-1:0]      in_wdata,
    input  logic [lsu_pkg::reg_addr_w-1:0] in_rd,
    // to MEM
    input  logic                          mem_allowin,
    output logic                          ex_to_mem_valid,
    output logic [lsu_pkg::xlen-1:0]      ex_pc,
    output lsu_pkg::lsu_op_e              ex_op,
    output logic [lsu_pkg::reg_addr_w-1:0] ex_rd,
    output logic [lsu_pkg::xlen-1:0]      ex_result,
    output logic                          ex_req,
    output logic                          ex_excp_ale,
    // data memory request
    output logic                          data_req,
    output logic                          data_wr,
    output logic [3:0]                    data_wstrb,
    output logic [lsu_pkg::xlen-1:0]      data_addr,
    output logic [lsu_pkg::xlen-1:0]      data_wdata,
    input  logic                          data_addr_ok
);

    logic                      ex_valid;
    logic                      ex_ready_go;
    logic [lsu_pkg::xlen-1:0]  base_q;
    logic [lsu_pkg::xlen-1:0]  offset_q;
    logic [lsu_pkg::xlen-1:0]  wdata_q;
    logic [lsu_pkg::xlen-1:0]  addr;
    logic                      mem_op;
    logic                      ale;

    assign in_ready        = ~ex_valid | (ex_ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ex_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_ready) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            ex_op    <= in_op;
            ex_pc    <= in_pc;
            ex_rd    <= in_rd;
            base_q   <= in_base;
            offset_q <= in_offset;
            wdata_q  <= in_wdata;
        end
    end

    assign addr   = base_q + offset_q;
    assign mem_op = lsu_pkg::is_load(ex_op) | lsu_pkg::is_store(ex_op);
    assign ale    = mem_op & lsu_pkg::is_misaligned(ex_op, addr[1:0]);

    // request only when MEM can take the instruction in the same cycle
    assign data_req    = ex_valid & mem_op & ~ale & mem_allowin;
    assign ex_ready_go = ~mem_op | ale | (data_req & data_addr_ok);

    assign ex_req      = mem_op & ~ale;
    assign ex_excp_ale = ale;
    assign ex_result   = mem_op ? addr : base_q;
    assign data_wr     = lsu_pkg::is_store(ex_op);
    assign data_addr   = addr;

    // lane replication and byte strobes, little endian
    always_comb begin
        case (ex_op)
            lsu_pkg::op_st_b: begin
                data_wstrb = 4'b0001 << addr[1:0];
                data_wdata = {4{wdata_q[7:0]}};
            end
            lsu_pkg::op_st_h: begin
                data_wstrb = addr[1] ? 4'b1100 : 4'b0011;
                data_wdata = {2{wdata_q[15:0]}};
            end
            lsu_pkg::op_st_w: begin
                data_wstrb = 4'b1111;
                data_wdata = wdata_q;
            end
            default: begin
                data_wstrb = 4'b0000;
                data_wdata = wdata_q;
            end
        endcase
    end

    // a waiting request keeps its address and data until accepted
    a_req_held_until_accepted: assert property (@(posedge clk) disable iff (!resetn)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr) &&
        $stable(data_wdata) && $stable(data_wr));

endmodule

//--- verilog/load_store_pipe.sv
`timescale 1ns/1ps

module load_store_pipe #(
    parameter int ram_words    = 256,
    parameter int resp_latency = 2
) (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  lsu_pkg::lsu_op_e               in_op,
    input  logic [lsu_pkg::xlen-1:0]       in_pc,
    input  logic [lsu_pkg::xlen-1:0]       in_base,
    input  logic [lsu_pkg::xlen-1:0]       in_offset,
    input  logic [lsu_pkg::xlen-1:0]       in_wdata,
    input  logic [lsu_pkg::reg_addr_w-1:0] in_rd,
    input  logic                           retire_ready,
    output logic                           retire_valid,
    output logic [lsu_pkg::xlen-1:0]       retire_pc,
    output logic [lsu_pkg::reg_addr_w-1:0] retire_rd,
    output logic                           retire_we,
    output logic [lsu_pkg::xlen-1:0]       retire_wdata,
    output logic                           retire_excp_ale
);

    // EX to MEM
    logic                           ex_to_mem_valid;
    logic                           mem_allowin;
    logic [lsu_pkg::xlen-1:0]       ex_pc;
    lsu_pkg::lsu_op_e               ex_op;
    logic [lsu_pkg::reg_addr_w-1:0] ex_rd;
    logic [lsu_pkg::xlen-1:0]       ex_result;
    logic                           ex_req;
    logic                           ex_excp_ale;
    // MEM to WB
    logic                           mem_to_wb_valid;
    logic                           wb_allowin;
    logic [lsu_pkg::xlen-1:0]       mem_pc;
    logic [lsu_pkg::reg_addr_w-1:0] mem_rd;
    logic                           mem_we;
    logic [lsu_pkg::xlen-1:0]       mem_wdata;
    logic                           mem_excp_ale;
    // memory bus
    logic                           data_req;
    logic                           data_wr;
    logic [3:0]                     data_wstrb;
    logic [lsu_pkg::xlen-1:0]       data_addr;
    logic [lsu_pkg::xlen-1:0]       data_wdata;
    logic                           data_addr_ok;
    logic                           data_ok;
    logic [lsu_pkg::xlen-1:0]       data_rdata;

    ex_stage ex_stage_inst (.*);

    mem_stage mem_stage_inst (.*);

    wb_stage wb_stage_inst (.*);

    data_ram #(
        .ram_words    (ram_words),
        .resp_latency (resp_latency)
    ) data_ram_inst (.*);

endmodule

//--- verilog/lsu_pkg.sv
package lsu_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // destination register number
    localparam int reg_addr_w = 5;

    typedef enum logic [3:0] {
        op_alu   = 4'd0,
        op_ld_b  = 4'd1,
        op_ld_bu = 4'd2,
        op_ld_h  = 4'd3,
        op_ld_hu = 4'd4,
        op_ld_w  = 4'd5,
        op_st_b  = 4'd6,
        op_st_h  = 4'd7,
        op_st_w  = 4'd8
    } lsu_op_e;

    function automatic logic is_load(lsu_op_e op);
        return (op == op_ld_b) || (op == op_ld_bu) || (op == op_ld_h) ||
               (op == op_ld_hu) || (op == op_ld_w);
    endfunction

    function automatic logic is_store(lsu_op_e op);
        return (op == op_st_b) || (op == op_st_h) || (op == op_st_w);
    endfunction

    // halfword and word accesses need natural alignment
    function automatic logic is_misaligned(lsu_op_e op, logic [1:0] low);
        return ((op == op_ld_h || op == op_ld_hu || op == op_st_h) && low[0]) ||
               ((op == op_ld_w || op == op_st_w) && (low != 2'b00));
    endfunction

endpackage

//--- verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                          clk,
    input  logic                          resetn,
    // from EX
    input  logic                          ex_to_mem_valid,
    output logic                          mem_allowin,
    input  logic [lsu_pkg::xlen-1:0]      ex_pc,
    input  lsu_pkg::lsu_op_e              ex_op,
    input  logic [lsu_pkg::reg_addr_w-1:0] ex_rd,
    input  logic [lsu_pkg::xlen-1:0]      ex_result,
    input  logic                          ex_req,
    input  logic                          ex_excp_ale,
    // data memory response
    input  logic                          data_ok,
    input  logic [lsu_pkg::xlen-1:0]      data_rdata,
    // to WB
    input  logic                          wb_allowin,
    output logic                          mem_to_wb_valid,
    output logic [lsu_pkg::xlen-1:0]      mem_pc,
    output logic [lsu_pkg::reg_addr_w-1:0] mem_rd,
    output logic                          mem_we,
    output logic [lsu_pkg::xlen-1:0]      mem_wdata,
    output logic                          mem_excp_ale
);

    logic                      mem_valid;
    logic                      mem_ready_go;
    lsu_pkg::lsu_op_e          op_q;
    logic [lsu_pkg::xlen-1:0]  result_q;
    logic                      req_q;
    logic                      got_resp;
    logic [lsu_pkg::xlen-1:0]  hold_rdata;
    logic [lsu_pkg::xlen-1:0]  rdata;
    logic [lsu_pkg::xlen-1:0]  shift_rdata;
    logic [lsu_pkg::xlen-1:0]  load_val;

    assign mem_ready_go    = ~req_q | got_resp | data_ok;
    assign mem_allowin     = ~mem_valid | (mem_ready_go & wb_allowin);
    assign mem_to_wb_valid = mem_valid & mem_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_pc       <= ex_pc;
            op_q         <= ex_op;
            mem_rd       <= ex_rd;
            result_q     <= ex_result;
            req_q        <= ex_req;
            mem_excp_ale <= ex_excp_ale;
        end
    end

    // keep the response while WB stalls us
    always_ff @(posedge clk) begin
        if (!resetn) begin
            got_resp <= 1'b0;
        end else if (mem_allowin) begin
            got_resp <= 1'b0;
        end else if (data_ok) begin
            got_resp <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok && !got_resp) begin
            hold_rdata <= data_rdata;
        end
    end

    assign rdata       = got_resp ? hold_rdata : data_rdata;
    assign shift_rdata = rdata >> {result_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            lsu_pkg::op_ld_b:  load_val = {{24{shift_rdata[7]}}, shift_rdata[7:0]};
            lsu_pkg::op_ld_bu: load_val = {24'b0, shift_rdata[7:0]};
            lsu_pkg::op_ld_h:  load_val = {{16{shift_rdata[15]}}, shift_rdata[15:0]};
            lsu_pkg::op_ld_hu: load_val = {16'b0, shift_rdata[15:0]};
            default:           load_val = shift_rdata;
        endcase
    end

    // faulting ops carry the bad address as data
    assign mem_wdata = (lsu_pkg::is_load(op_q) && !mem_excp_ale) ? load_val : result_q;
    assign mem_we    = ~mem_excp_ale & ((op_q == lsu_pkg::op_alu) | lsu_pkg::is_load(op_q));

    a_resp_only_when_waiting: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> mem_valid && req_q && !got_resp);

endmodule

//--- verilog/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                          clk,
    input  logic                          resetn,
    // from MEM
    input  logic                          mem_to_wb_valid,
    output logic                          wb_allowin,
    input  logic [lsu_pkg::xlen-1:0]      mem_pc,
    input  logic [lsu_pkg::reg_addr_w-1:0] mem_rd,
    input  logic                          mem_we,
    input  logic [lsu_pkg::xlen-1:0]      mem_wdata,
    input  logic                          mem_excp_ale,
    // retire port
    input  logic                          retire_ready,
    output logic                          retire_valid,
    output logic [lsu_pkg::xlen-1:0]      retire_pc,
    output logic [lsu_pkg::reg_addr_w-1:0] retire_rd,
    output logic                          retire_we,
    output logic [lsu_pkg::xlen-1:0]      retire_wdata,
    output logic                          retire_excp_ale
);

    logic wb_valid;

    // nothing to wait for here besides the consumer
    assign wb_allowin   = ~wb_valid | retire_ready;
    assign retire_valid = wb_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            retire_pc       <= mem_pc;
            retire_rd       <= mem_rd;
            retire_we       <= mem_we;
            retire_wdata    <= mem_wdata;
            retire_excp_ale <= mem_excp_ale;
        end
    end

    a_retire_hold: assert property (@(posedge clk) disable iff (!resetn)
        retire_valid && !retire_ready |=> retire_valid &&
        $stable(retire_pc) && $stable(retire_rd) && $stable(retire_we) &&
        $stable(retire_wdata) && $stable(retire_excp_ale));

endmodule
